/* list.f */
rtl/imuldiv_msg_pkg.sv
rtl/imuldiv_ctrl_pkg.sv
rtl/int_mul_iterative.sv
rtl/int_div_iterative.sv
rtl/muldiv_resp_order.sv
rtl/imuldiv_top.sv
tb/imuldiv_tb.sv

/* Makefile */
# Verilator build and run for the mul/div unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log, check the result"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv --top-module imuldiv_tb -f list.f \
		-Mdir obj_dir -o imuldiv_sim
	./obj_dir/imuldiv_sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/imuldiv_tb.sv */
/*
 * testbench for the mul/div unit, every response is checked against a reference model
 * responses are matched strictly in issue order, the run ends at a fixed cycle limit
 */
`timescale 1ns/1ps

module imuldiv_tb;

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int N_RAND       = 40;
  localparam int N_MIX        = 60;
  // 16 corner pairs each for mul and div, 8 divide-by-zero cases
  localparam int N_REQ        = 16 + N_RAND + N_RAND + 16 + N_RAND + 8 + N_MIX;
  localparam int TIMEOUT      = N_REQ * (ITER_COUNT + 8) * 4 + RESET_CYCLES;
  localparam logic [31:0] SEED = 32'h1a11;

  logic         clk = 1'b0;
  logic         reset;
  muldiv_req_t  req;
  logic         req_val;
  logic         req_rdy;
  muldiv_resp_t resp;
  logic         resp_val;
  logic         resp_rdy = 1'b1;

  // expected responses, oldest first
  muldiv_resp_t exp_q[$];
  muldiv_resp_t exp_head;
  string        cur_test = "reset";
  bit           mon_ok;
  int           mon_pass = 0;
  int           mon_fail = 0;
  int           main_pass = 0;
  int           main_fail = 0;
  int           fail_mark = 0;
  int           issued = 0;
  int           received = 0;
  int           cycles = 0;
  logic         rdy_random = 1'b0;
  logic [31:0]  op_seed = SEED;
  logic [31:0]  rdy_seed = SEED;

  // zero, minus one, most negative, most positive
  logic [31:0] corner [4] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
  // every sign combination, plus the overflow pair
  logic [31:0] dcorner [4] = '{32'd7, 32'hffff_fff9, 32'h8000_0000, 32'hffff_ffff};

  imuldiv_top dut0 (
    .clk(clk), .reset(reset),
    .req(req), .req_val(req_val), .req_rdy(req_rdy),
    .resp(resp), .resp_val(resp_val), .resp_rdy(resp_rdy)
  );

  always #10 clk = ~clk;

  // ------------------------------
  // random numbers and reference
  // ------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    op_seed = lcg_step(op_seed);
    return op_seed;
  endfunction

  // expected hi:lo straight from the arithmetic rules
  function automatic muldiv_resp_t ref_result(input muldiv_fn_e fn, input logic [31:0] a,
                                              input logic [31:0] b);
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    muldiv_resp_t       r;
    wa = {{32{a[31]}}, a};
    wb = {{32{b[31]}}, b};
    sa = a;
    sb = b;
    if (fn == FN_MUL) begin
      r = wa * wb;
    end else if (b == 32'd0) begin
      // divide by zero, quotient all ones and remainder is the dividend
      r.hi = a;
      r.lo = '1;
    end else if (fn == FN_DIVU) begin
      r.hi = a % b;
      r.lo = a / b;
    end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // signed overflow wraps back to the dividend
      r.hi = '0;
      r.lo = a;
    end else begin
      // truncating divide, remainder follows the dividend sign
      r.hi = sa % sb;
      r.lo = sa / sb;
    end
    return r;
  endfunction

  // ------------------------------
  // checking
  // ------------------------------
  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual, output bit ok);
    ok = (actual === expected);
    if (!ok)
      $display("Error: %s expected %h actual %h", name, expected, actual);
  endtask

  task automatic tally(input bit ok);
    if (ok) main_pass++;
    else main_fail++;
  endtask

  // one request, inputs change on the falling edge only
  task automatic issue(input muldiv_fn_e fn, input logic [31:0] a, input logic [31:0] b);
    req.fn = fn;
    req.a = a;
    req.b = b;
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    exp_q.push_back(ref_result(fn, a, b));
    issued++;
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // wait for outstanding responses, then report the test
  task automatic finish_test();
    while (exp_q.size() != 0) @(negedge clk);
    $display("test %s done, %0d errors", cur_test, mon_fail + main_fail - fail_mark);
    fail_mark = mon_fail + main_fail;
  endtask

  // response monitor, pops one expected value per handshake
  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      received++;
      if (exp_q.size() == 0) begin
        $display("%s: response arrived with no request outstanding", cur_test);
        mon_fail++;
      end else begin
        exp_head = exp_q.pop_front();
        compare(cur_test, exp_head, resp, mon_ok);
        if (mon_ok) mon_pass++;
        else mon_fail++;
      end
    end
  end

  // back-pressure source, its own seed stream
  always @(negedge clk) begin
    rdy_seed = lcg_step(rdy_seed);
    resp_rdy = rdy_random ? rdy_seed[20] : 1'b1;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    muldiv_fn_e  fn;
    bit          ok;
    reset = 1'b1;
    req_val = 1'b0;
    req = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // idle unit must accept and have nothing to return
    compare(cur_test, 64'b10, 64'({req_rdy, resp_val}), ok);
    tally(ok);
    finish_test();

    cur_test = "mul";
    for (int i = 0; i < 4; i++)
      for (int j = 0; j < 4; j++) issue(FN_MUL, corner[i], corner[j]);
    for (int i = 0; i < N_RAND; i++) begin
      a = next_rand();
      b = next_rand();
      issue(FN_MUL, a, b);
    end
    finish_test();

    cur_test = "divu";
    for (int i = 0; i < N_RAND; i++) begin
      a = next_rand();
      b = next_rand();
      r = next_rand();
      // smaller divisors give wider quotients
      b = b >> r[4:0];
      issue(FN_DIVU, a, b);
    end
    finish_test();

    cur_test = "div";
    for (int i = 0; i < 4; i++)
      for (int j = 0; j < 4; j++) issue(FN_DIV, dcorner[i], dcorner[j]);
    for (int i = 0; i < N_RAND; i++) begin
      a = next_rand();
      b = next_rand();
      r = next_rand();
      b = $signed(b) >>> r[4:0];
      issue(FN_DIV, a, b);
    end
    finish_test();

    cur_test = "divzero";
    for (int i = 0; i < 4; i++) begin
      issue(FN_DIV, corner[i], 32'd0);
      issue(FN_DIVU, corner[i], 32'd0);
    end
    finish_test();

    // mixed stream under random back-pressure
    cur_test = "mixed";
    rdy_random = 1'b1;
    for (int i = 0; i < N_MIX; i++) begin
      r = next_rand();
      fn = r[16] ? FN_MUL : (r[17] ? FN_DIV : FN_DIVU);
      a = next_rand();
      b = next_rand();
      issue(fn, a, b);
    end
    while (exp_q.size() != 0) @(negedge clk);
    rdy_random = 1'b0;
    // idle time exposes any duplicated response
    repeat (40) @(negedge clk);
    compare("mixed count", 64'(issued), 64'(received), ok);
    tally(ok);
    finish_test();

    $display("checks passed %0d, failed %0d", mon_pass + main_pass, mon_fail + main_fail);
    if (mon_fail + main_fail == 0) $display("STATUS: PASS");
    else $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* rtl/imuldiv_top.sv */
/*
 * mul/div unit top, one multiply and one divide may be in flight at once
 * responses always leave in the order the requests were accepted
 */
`timescale 1ns/1ps

module imuldiv_top (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_msg_pkg::muldiv_req_t  req,
  input  logic                          req_val,
  output logic                          req_rdy,
  output imuldiv_msg_pkg::muldiv_resp_t resp,
  output logic                          resp_val,
  input  logic                          resp_rdy
);

  import imuldiv_msg_pkg::*;

  // ------------------------------
  // unit handshakes
  // ------------------------------
  logic         mul_req_val, mul_req_rdy, mul_resp_val, mul_resp_rdy;
  logic         div_req_val, div_req_rdy, div_resp_val, div_resp_rdy;
  muldiv_resp_t mul_resp;
  muldiv_resp_t div_resp;

  // both units see the same request, val decides who captures it
  int_mul_iterative mul0 (
    .clk(clk), .reset(reset),
    .req(req), .req_val(mul_req_val), .req_rdy(mul_req_rdy),
    .resp_val(mul_resp_val), .resp(mul_resp), .resp_rdy(mul_resp_rdy)
  );

  int_div_iterative div0 (
    .clk(clk), .reset(reset),
    .req(req), .req_val(div_req_val), .req_rdy(div_req_rdy),
    .resp_val(div_resp_val), .resp(div_resp), .resp_rdy(div_resp_rdy)
  );

  muldiv_resp_order order0 (
    .clk(clk), .reset(reset),
    .req_fn(req.fn), .req_val(req_val), .req_rdy(req_rdy),
    .mul_req_val(mul_req_val), .mul_req_rdy(mul_req_rdy),
    .div_req_val(div_req_val), .div_req_rdy(div_req_rdy),
    .mul_resp_val(mul_resp_val), .mul_resp(mul_resp), .mul_resp_rdy(mul_resp_rdy),
    .div_resp_val(div_resp_val), .div_resp(div_resp), .div_resp_rdy(div_resp_rdy),
    .resp_val(resp_val), .resp(resp), .resp_rdy(resp_rdy)
  );

endmodule

/* rtl/muldiv_resp_order.sv */
/*
 * steers requests to the mul or div unit and returns responses in issue order
 * purely combinational paths, the only state is the unit-tag queue
 */
`timescale 1ns/1ps

module muldiv_resp_order (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_msg_pkg::muldiv_fn_e   req_fn,
  input  logic                          req_val,
  output logic                          req_rdy,
  output logic                          mul_req_val,
  input  logic                          mul_req_rdy,
  output logic                          div_req_val,
  input  logic                          div_req_rdy,
  input  logic                          mul_resp_val,
  input  imuldiv_msg_pkg::muldiv_resp_t mul_resp,
  output logic                          mul_resp_rdy,
  input  logic                          div_resp_val,
  input  imuldiv_msg_pkg::muldiv_resp_t div_resp,
  output logic                          div_resp_rdy,
  output logic                          resp_val,
  output imuldiv_msg_pkg::muldiv_resp_t resp,
  input  logic                          resp_rdy
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  localparam int PTR_W = $clog2(ORDER_DEPTH);
  localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

  // tag 1 = divider, 0 = multiplier
  logic [ORDER_DEPTH-1:0] tags;
  logic [PTR_W-1:0]       rd_ptr;
  logic [PTR_W-1:0]       wr_ptr;
  logic [CNT_W-1:0]       cnt;

  logic full;
  logic empty;
  logic is_div;
  logic head_div;
  logic push;
  logic pop;

  assign full     = (cnt == CNT_W'(ORDER_DEPTH));
  assign empty    = (cnt == '0);
  assign is_div   = (req_fn != FN_MUL);
  assign head_div = tags[rd_ptr];

  // ------------------------------
  // request steering
  // ------------------------------
  assign req_rdy     = !full && (is_div ? div_req_rdy : mul_req_rdy);
  assign mul_req_val = req_val && !full && !is_div;
  assign div_req_val = req_val && !full && is_div;
  assign push        = req_val && req_rdy;

  // ------------------------------
  // response selection
  // ------------------------------
  // only the head unit may hand back a result
  assign resp_val     = !empty && (head_div ? div_resp_val : mul_resp_val);
  assign resp         = head_div ? div_resp : mul_resp;
  assign mul_resp_rdy = !empty && !head_div && resp_rdy;
  assign div_resp_rdy = !empty && head_div && resp_rdy;
  assign pop          = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      cnt <= cnt + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // tag storage
  always_ff @(posedge clk) begin
    if (push) tags[wr_ptr] <= is_div;
  end

  // a full queue means both units are busy, so nothing is left to push
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    full |-> (!mul_req_rdy && !div_req_rdy));
  // an empty queue means no unit holds a result waiting to be popped
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    empty |-> (!mul_resp_val && !div_resp_val));

endmodule

/* rtl/int_div_iterative.sv */
/*
 * restoring divider, remainder in hi and quotient in lo, one request at a time
 * divide by zero gives quotient all ones and remainder equal to the dividend
 */
`timescale 1ns/1ps

module int_div_iterative (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_msg_pkg::muldiv_req_t  req,
  input  logic                          req_val,
  output logic                          req_rdy,
  output logic                          resp_val,
  output imuldiv_msg_pkg::muldiv_resp_t resp,
  input  logic                          resp_rdy
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  unit_state_e       state;
  logic [ITER_W-1:0] count;

  // remainder in [64:32]
  // quotient shifts in at [31:0]
  logic [64:0] rq;
  // divisor aligned to the remainder half
  logic [64:0] dvs;
  logic        quo_neg;
  logic        rem_neg;
  logic        div_zero;

  logic        is_signed;
  logic        use_raw;
  logic [31:0] a_in;
  logic [31:0] b_in;
  logic [64:0] shifted;
  logic [64:0] diff;

  assign is_signed = (req.fn == FN_DIV);

  // unsigned ops and divide by zero skip the magnitude step
  // so the remainder comes out as the dividend itself
  assign use_raw = !is_signed || (req.b == 32'd0);
  assign a_in    = (use_raw || !req.a[31]) ? req.a : (~req.a + 32'd1);
  assign b_in    = (use_raw || !req.b[31]) ? req.b : (~req.b + 32'd1);

  // one restoring step
  assign shifted = rq << 1;
  assign diff    = shifted - dvs;

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);
  assign resp     = {rq[63:32], rq[31:0]};

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: if (req_val) begin
          state <= ST_CALC;
          count <= '0;
        end
        ST_CALC: begin
          count <= count + 1'b1;
          if (count == ITER_W'(ITER_COUNT - 1)) state <= ST_FIX;
        end
        ST_FIX:  state <= ST_DONE;
        ST_DONE: if (resp_rdy) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: if (req_val) begin
        rq       <= {33'b0, a_in};
        dvs      <= {1'b0, b_in, 32'b0};
        quo_neg  <= is_signed && (req.a[31] ^ req.b[31]);
        rem_neg  <= is_signed && req.a[31];
        div_zero <= (req.b == 32'd0);
      end
      ST_CALC: begin
        // a negative difference restores and shifts in a quotient 0
        if (diff[64]) rq <= {shifted[64:1], 1'b0};
        else          rq <= {diff[64:1], 1'b1};
      end
      ST_FIX: if (!div_zero) begin
        // remainder takes the dividend sign
        if (rem_neg) rq[63:32] <= ~rq[63:32] + 32'd1;
        if (quo_neg) rq[31:0]  <= ~rq[31:0] + 32'd1;
      end
      default: ;
    endcase
  end

  // iteration counter stays within its range
  a_count_range: assert property (@(posedge clk) disable iff (reset)
    count <= ITER_W'(ITER_COUNT));

  // a finished result waits unchanged for the response handshake
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)));

endmodule

/* rtl/int_mul_iterative.sv */
/*
 * signed 32x32 shift-add multiplier, full 64-bit product, one request at a time
 * fixed latency of ITER_COUNT+1 cycles, no early termination
 */
`timescale 1ns/1ps

module int_mul_iterative (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_msg_pkg::muldiv_req_t  req,
  input  logic                          req_val,
  output logic                          req_rdy,
  output logic                          resp_val,
  output imuldiv_msg_pkg::muldiv_resp_t resp,
  input  logic                          resp_rdy
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  unit_state_e       state;
  logic [ITER_W-1:0] count;

  // datapath registers
  logic [63:0] mcand;
  logic [31:0] mplier;
  logic [63:0] acc;
  logic        neg;

  // operand magnitudes with the most negative value mapping to 2^31 unsigned
  logic [31:0] a_mag;
  logic [31:0] b_mag;

  assign a_mag = req.a[31] ? (~req.a + 32'd1) : req.a;
  assign b_mag = req.b[31] ? (~req.b + 32'd1) : req.b;

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);
  assign resp     = acc;

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: if (req_val) begin
          state <= ST_CALC;
          count <= '0;
        end
        ST_CALC: begin
          count <= count + 1'b1;
          // the sign fix follows the last add step
          if (count == ITER_W'(ITER_COUNT - 1)) state <= ST_FIX;
        end
        ST_FIX:  state <= ST_DONE;
        ST_DONE: if (resp_rdy) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: if (req_val) begin
        mcand  <= {32'b0, a_mag};
        mplier <= b_mag;
        acc    <= '0;
        neg    <= req.a[31] ^ req.b[31];
      end
      ST_CALC: begin
        // add the shifted multiplicand for each set multiplier bit from the lsb up
        if (mplier[0]) acc <= acc + mcand;
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
      ST_FIX: if (neg) acc <= ~acc + 64'd1;
      default: ;
    endcase
  end

  // a finished product waits unchanged for the response handshake
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)));

  // result shows up ITER_COUNT+1 edges after accept
  a_latency: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |-> ##(ITER_COUNT + 2) resp_val);

endmodule

/* rtl/imuldiv_ctrl_pkg.sv */
/*
 * control constants and the state encoding used by both iterative units
 * ORDER_DEPTH must stay a power of two, the order queue wraps its pointers
 */

package imuldiv_ctrl_pkg;

  // ------------------------------
  // iteration and queue sizing
  // ------------------------------

  // one iteration per operand bit
  localparam int ITER_COUNT = 32;

  // counter must be able to hold ITER_COUNT itself
  localparam int ITER_W = 6;

  // one entry per unit, each unit holds at most one request
  localparam int ORDER_DEPTH = 2;

  // ------------------------------
  // unit FSM
  // ------------------------------

  // idle -> calc (ITER_COUNT cycles) -> fix (one cycle) -> done
  typedef enum logic [1:0] {
    ST_IDLE, ST_CALC, ST_FIX, ST_DONE
  } unit_state_e;

endpackage

/* rtl/imuldiv_msg_pkg.sv */
/*
 * request and response formats shared by the mul/div unit and its sub-blocks
 * operands are always 32 bits, results always 64 bits (hi:lo)
 */

package imuldiv_msg_pkg;

  // ------------------------------
  // function codes
  // ------------------------------

  // only three codes are used, the fourth encoding is reserved
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_e;

  // ------------------------------
  // messages
  // ------------------------------

  // 66-bit request, fn in the top two bits
  typedef struct packed {
    muldiv_fn_e  fn;
    logic [31:0] a;
    logic [31:0] b;
  } muldiv_req_t;

  // multiply: hi:lo is the full product
  // divide: hi is remainder, lo is quotient
  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } muldiv_resp_t;

endpackage
